//--- verilog/gc_cfg.svh
/*
 * GameCube controller emulator configuration
 * Quarter-bit timing, frame idle timeout and AXI4-Lite register map
 */
`ifndef GC_CFG_SVH
`define GC_CFG_SVH

// Clock cycles per quarter bit, small for simulation
`define GC_QUARTER_CYCLES 4

// Line high this many quarters ends a console frame
`define GC_IDLE_QUARTERS 8

// AXI byte offsets
`define GC_REG_STATE_LO 4'h0
`define GC_REG_STATE_HI 4'h4
`define GC_REG_STATUS   4'h8

`endif

//--- verilog/gc_pkg.sv
/*
 * GameCube controller emulator types
 * Console commands, controller FSM states, receive events, AXI responses
 */
`default_nettype none

package gc_pkg;

	// Recognized console commands
	typedef enum logic [1:0] {
		CMD_NONE    = 2'd0,
		CMD_ID      = 2'd1,
		CMD_STATUS  = 2'd2,
		CMD_ORIGINS = 2'd3
	} gc_cmd_e;

	// Controller FSM
	typedef enum logic [1:0] {
		ST_RX   = 2'd0, // Decoding console bits
		ST_TX   = 2'd1, // Sending response payload
		ST_STOP = 2'd2  // Sending final stop bit
	} ctrl_state_e;

	// One-cycle events from the bit detector
	typedef struct packed {
		logic start;  // First falling edge of a frame
		logic strobe; // One bit decoded
		logic data;   // Value of that bit
		logic stop;   // Line idle after a frame
		logic error;  // Line held low too long
	} rx_event_t;

	// AXI4-Lite response codes
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_SLVERR = 2'd2
	} axi_resp_e;

endpackage

`default_nettype wire

//--- verilog/gc_quarter_timer.sv
/*
 * Quarter-bit timebase
 * Free-running down counter, one-cycle tick at each quarter boundary
 */
`timescale 1ns/1ps
`default_nettype none
`include "gc_cfg.svh"

module gc_quarter_timer (
	input  logic clk,
	input  logic reset,
	output logic tick
);
	localparam int CNT_W = $clog2(`GC_QUARTER_CYCLES + 1);
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`GC_QUARTER_CYCLES - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			cnt <= RELOAD;
		else if (cnt == '0)
			cnt <= RELOAD; // Wrap
		else
			cnt <= cnt - 1'b1;
	end

	assign tick = (cnt == '0); // Last cycle of each quarter

endmodule

`default_nettype wire

//--- verilog/joybus_bit_detector.sv
/*
 * Joybus bit detector
 * Synchronizes the line, times low and high phases, and reports
 * frame start, decoded bits, frame stop and stuck-low errors
 */
`timescale 1ns/1ps
`default_nettype none
`include "gc_cfg.svh"

module joybus_bit_detector import gc_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      rx_line,
	output rx_event_t rx_evt
);
	localparam int LIMIT = `GC_IDLE_QUARTERS * `GC_QUARTER_CYCLES;
	localparam int CNT_W = $clog2(LIMIT + 1);
	localparam logic [CNT_W-1:0] CNT_MAX   = CNT_W'(LIMIT);
	localparam logic [CNT_W-1:0] CNT_LAST  = CNT_W'(LIMIT - 1);
	localparam logic [CNT_W-1:0] SHORT_LOW = CNT_W'(2 * `GC_QUARTER_CYCLES);

	logic [1:0]       sync_q;   // Two-flop synchronizer
	logic             line;
	logic             line_d;
	logic             in_frame; // Between start and stop
	logic [CNT_W-1:0] low_cnt;
	logic [CNT_W-1:0] high_cnt;
	logic             fall;
	logic             rise;

	assign line = sync_q[1];
	assign fall = line_d & ~line;
	assign rise = ~line_d & line;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sync_q   <= 2'b11; // Idle high
			line_d   <= 1'b1;
			in_frame <= 1'b0;
			low_cnt  <= '0;
			high_cnt <= '0;
			rx_evt   <= '0;
		end else begin
			sync_q <= {sync_q[0], rx_line};
			line_d <= line;
			rx_evt <= '0; // Events last one cycle

			// Saturating phase counters
			if (line) begin
				low_cnt <= '0;
				if (high_cnt != CNT_MAX)
					high_cnt <= high_cnt + 1'b1;
			end else begin
				high_cnt <= '0;
				if (low_cnt != CNT_MAX)
					low_cnt <= low_cnt + 1'b1;
			end

			if (fall && !in_frame) begin
				in_frame     <= 1'b1;
				rx_evt.start <= 1'b1;
			end

			// Short low means a 1
			if (rise && in_frame) begin
				rx_evt.strobe <= 1'b1;
				rx_evt.data   <= (low_cnt < SHORT_LOW);
			end

			if (!line && in_frame && low_cnt == CNT_LAST) begin
				rx_evt.error <= 1'b1; // Stuck low, drop the frame
				in_frame     <= 1'b0;
			end

			if (line && in_frame && high_cnt == CNT_LAST) begin
				rx_evt.stop <= 1'b1;
				in_frame    <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/joybus_bit_generator.sv
/*
 * Joybus bit generator
 * Takes one bit per four quarters and shapes it into pull-low pulses,
 * back to back with no gap between accepted bits
 */
`timescale 1ns/1ps
`default_nettype none

module joybus_bit_generator (
	input  logic clk,
	input  logic reset,
	input  logic tick,
	input  logic bit_valid,
	input  logic bit_data,
	output logic bit_ready,
	output logic tx_low
);
	logic       busy;
	logic [1:0] quarter;
	logic       data_q; // Bit being sent
	logic       idle;
	logic [1:0] quarter_nxt;

	// Last quarter counts as idle so the next bit follows directly
	assign idle        = !busy || (quarter == 2'd3);
	assign bit_ready   = tick && idle && bit_valid;
	assign quarter_nxt = quarter + 2'd1;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy    <= 1'b0;
			quarter <= 2'd0;
			tx_low  <= 1'b0;
		end else if (tick) begin
			if (idle) begin
				busy    <= bit_valid;
				quarter <= 2'd0;
				tx_low  <= bit_valid; // Quarter 0 always low
			end else begin
				quarter <= quarter_nxt;
				tx_low  <= !data_q && (quarter_nxt != 2'd3); // Quarters 1 and 2 for a 0
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bit_ready)
			data_q <= bit_data;
	end

endmodule

`default_nettype wire

//--- verilog/gc_controller.sv
/*
 * GameCube controller FSM
 * Matches console commands bit by bit, then feeds the response bits
 * and the closing stop bit to the bit generator
 */
`timescale 1ns/1ps
`default_nettype none
`include "gc_cfg.svh"

module gc_controller import gc_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  rx_event_t rx_evt,
	input  logic      bit_ready,
	output logic      bit_valid,
	output logic      bit_data,
	output logic [5:0] state_addr,
	input  logic      state_bit,
	output logic      rumble,
	output gc_cmd_e   last_cmd
);
	localparam int WAIT_W = $clog2(4 * `GC_QUARTER_CYCLES + 1);
	localparam logic [WAIT_W-1:0] GAP      = WAIT_W'(`GC_QUARTER_CYCLES);
	localparam logic [WAIT_W-1:0] BIT_TIME = WAIT_W'(4 * `GC_QUARTER_CYCLES);

	localparam logic [8:0]  ORG_PAT    = 9'b0100_0001_1; // 0x41 plus stop
	localparam logic [15:0] STATUS_PAT = 16'h4003;
	localparam logic [23:0] ID_RESP    = 24'h09_00_00;
	localparam logic [79:0] ORG_RESP   = 80'h00_80_80_80_80_80_00_00_02_02;

	ctrl_state_e       state;
	logic [6:0]        bit_cnt;     // Rx strobes or tx bits
	logic              cand_id;     // Still-possible commands
	logic              cand_status;
	logic              cand_origins;
	logic              pend_rumble; // Flags bit 0 until frame completes
	logic              stop_sent;
	logic [WAIT_W-1:0] wait_cnt;
	logic              id_ok;
	logic              status_ok;
	logic              org_ok;
	logic [2:0]        done_vec;
	logic [6:0]        resp_len;
	logic              resp_bit;

	// Does the current rx bit fit each command
	always_comb begin
		id_ok  = (bit_cnt <= 7'd8) && (rx_evt.data == (bit_cnt == 7'd8));
		org_ok = (bit_cnt <= 7'd8) && (rx_evt.data == ORG_PAT[4'(7'd8 - bit_cnt)]);
		if (bit_cnt < 7'd16)
			status_ok = (rx_evt.data == STATUS_PAT[4'(7'd15 - bit_cnt)]);
		else if (bit_cnt < 7'd24)
			status_ok = 1'b1; // Flags byte
		else if (bit_cnt == 7'd24)
			status_ok = rx_evt.data; // Stop bit
		else
			status_ok = 1'b0; // Too long
	end

	// Completed at stop: counts include the console stop bit
	assign done_vec = {cand_id && bit_cnt == 7'd9,
	                   cand_status && bit_cnt == 7'd25,
	                   cand_origins && bit_cnt == 7'd9};

	// Response source per command, MSB first
	always_comb begin
		case (last_cmd)
			CMD_ID: begin
				resp_len = 7'd24;
				resp_bit = ID_RESP[5'(7'd23 - bit_cnt)];
			end
			CMD_ORIGINS: begin
				resp_len = 7'd80;
				resp_bit = ORG_RESP[7'd79 - bit_cnt];
			end
			default: begin
				resp_len = 7'd64;
				resp_bit = state_bit; // Stored state, fetched by index
			end
		endcase
	end

	assign state_addr = bit_cnt[5:0];
	assign bit_valid  = (wait_cnt == '0) &&
	                    (state == ST_TX || (state == ST_STOP && !stop_sent));
	assign bit_data   = (state == ST_STOP) ? 1'b1 : resp_bit;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state        <= ST_RX;
			bit_cnt      <= '0;
			cand_id      <= 1'b1;
			cand_status  <= 1'b1;
			cand_origins <= 1'b1;
			pend_rumble  <= 1'b0;
			stop_sent    <= 1'b0;
			wait_cnt     <= '0;
			rumble       <= 1'b0;
			last_cmd     <= CMD_NONE;
		end else begin
			if (wait_cnt != '0)
				wait_cnt <= wait_cnt - 1'b1;

			case (state)
				ST_RX: begin
					if (rx_evt.start || rx_evt.stop) begin
						// Re-arm all matchers
						cand_id      <= 1'b1;
						cand_status  <= 1'b1;
						cand_origins <= 1'b1;
						bit_cnt      <= '0;
					end else if (rx_evt.error) begin
						cand_id      <= 1'b0;
						cand_status  <= 1'b0;
						cand_origins <= 1'b0;
					end else if (rx_evt.strobe) begin
						cand_id      <= cand_id & id_ok;
						cand_status  <= cand_status & status_ok;
						cand_origins <= cand_origins & org_ok;
						if (bit_cnt == 7'd23)
							pend_rumble <= rx_evt.data;
						if (bit_cnt != 7'd127)
							bit_cnt <= bit_cnt + 1'b1;
					end

					if (rx_evt.stop && done_vec inside {3'b100, 3'b010, 3'b001}) begin
						state     <= ST_TX;
						wait_cnt  <= GAP; // Turnaround before first bit
						stop_sent <= 1'b0;
						if (done_vec[2])
							last_cmd <= CMD_ID;
						else if (done_vec[1]) begin
							last_cmd <= CMD_STATUS;
							rumble   <= pend_rumble;
						end else
							last_cmd <= CMD_ORIGINS;
					end
				end
				ST_TX: begin
					if (bit_ready) begin
						if (bit_cnt == resp_len - 7'd1) begin
							state   <= ST_STOP;
							bit_cnt <= '0;
						end else
							bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: begin // ST_STOP
					if (bit_ready) begin
						stop_sent <= 1'b1;
						wait_cnt  <= BIT_TIME; // Let the stop bit finish
					end else if (stop_sent && wait_cnt == '0)
						state <= ST_RX;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/gc_state_regs.sv
/*
 * AXI4-Lite register block
 * 64-bit controller state with byte strobes, plus rumble and last command
 * status; serves state bits to the controller by response index
 */
`timescale 1ns/1ps
`default_nettype none
`include "gc_cfg.svh"

module gc_state_regs import gc_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [3:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output axi_resp_e   bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output axi_resp_e   rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic [5:0]  state_addr,
	output logic        state_bit,
	input  logic        rumble,
	input  gc_cmd_e     last_cmd
);
	logic [31:0] state_lo; // Bytes 0 to 3
	logic [31:0] state_hi; // Bytes 4 to 7
	logic        wr_go;
	logic        rd_go;

	// Address and data taken together, stalled by a pending response
	assign wr_go   = awvalid && wvalid && !bvalid;
	assign awready = wr_go;
	assign wready  = wr_go;
	assign rd_go   = arvalid && !rvalid;
	assign arready = rd_go;

	// Byte i/8, bit 7-(i mod 8)
	assign state_bit = {state_hi, state_lo}[{state_addr[5:3], ~state_addr[2:0]}];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (wr_go)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rd_go)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_go) begin
			bresp <= RESP_OKAY;
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i] && awaddr == `GC_REG_STATE_LO)
					state_lo[8*i +: 8] <= wdata[8*i +: 8];
				if (wstrb[i] && awaddr == `GC_REG_STATE_HI)
					state_hi[8*i +: 8] <= wdata[8*i +: 8];
			end
			if (awaddr != `GC_REG_STATE_LO && awaddr != `GC_REG_STATE_HI)
				bresp <= RESP_SLVERR; // STATUS is read only
		end
		if (rd_go) begin
			rresp <= RESP_OKAY;
			case (araddr)
				`GC_REG_STATE_LO: rdata <= state_lo;
				`GC_REG_STATE_HI: rdata <= state_hi;
				`GC_REG_STATUS:   rdata <= {26'd0, last_cmd, 3'd0, rumble};
				default: begin
					rdata <= 32'd0;
					rresp <= RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/gc_emulator_top.sv
/*
 * GameCube controller emulator, single port
 * AXI4-Lite state registers driving a joybus responder
 */
`timescale 1ns/1ps
`default_nettype none

module gc_emulator_top import gc_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [3:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output axi_resp_e   bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output axi_resp_e   rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic        rx_line, // Sampled open-drain pin
	output logic        tx_low   // Pull the pin low
);
	logic       tick;
	rx_event_t  rx_evt;
	logic       bit_valid;
	logic       bit_data;
	logic       bit_ready;
	logic [5:0] state_addr;
	logic       state_bit;
	logic       rumble;
	gc_cmd_e    last_cmd;

	gc_quarter_timer u_timer (.clk, .reset, .tick);

	joybus_bit_detector u_detector (.clk, .reset, .rx_line, .rx_evt);

	joybus_bit_generator u_generator (
		.clk, .reset, .tick, .bit_valid, .bit_data, .bit_ready, .tx_low
	);

	gc_controller u_controller (
		.clk, .reset, .rx_evt, .bit_ready, .bit_valid, .bit_data,
		.state_addr, .state_bit, .rumble, .last_cmd
	);

	gc_state_regs u_regs (
		.clk, .reset,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.state_addr, .state_bit, .rumble, .last_cmd
	);

endmodule

`default_nettype wire

//--- dv/gc_emulator_assertions.sv
/*
 * Bound checks for the emulator top level
 * AXI response hold, quarter tick width, line ownership while answering
 */
`timescale 1ns/1ps
`default_nettype none

module gc_emulator_assertions import gc_pkg::*; (
	input logic        clk,
	input logic        reset,
	input logic        bvalid,
	input logic        bready,
	input axi_resp_e   bresp,
	input logic        rvalid,
	input logic        rready,
	input axi_resp_e   rresp,
	input logic [31:0] rdata,
	input logic        tick,
	input logic        tx_low,
	input ctrl_state_e state
);
	// Write response waits for bready
	assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("bvalid or bresp changed while bready was low");

	// Read data waits for rready
	assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
		else $error("rvalid, rresp or rdata changed while rready was low");

	assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
		else $error("quarter tick lasted more than one cycle");

	// Pull-low only while the FSM owns the line
	assert property (@(posedge clk) disable iff (reset) tx_low |-> state != ST_RX)
		else $error("tx_low asserted while the controller was receiving");

endmodule

bind gc_emulator_top gc_emulator_assertions u_gc_emulator_assertions (
	.clk, .reset, .bvalid, .bready, .bresp, .rvalid, .rready, .rresp, .rdata,
	.tick, .tx_low, .state(u_controller.state)
);

`default_nettype wire

//--- dv/gc_emulator_tb.sv
/*
 * GameCube controller emulator testbench
 * Console model on the joybus line, AXI4-Lite host tasks and a table of
 * command frames with their expected answers and status
 */
`timescale 1ns/1ps
`default_nettype none
`include "gc_cfg.svh"

module gc_emulator_tb import gc_pkg::*; ();
	localparam int QC      = `GC_QUARTER_CYCLES;
	localparam int BIT_CYC = 4 * QC;
	localparam int NROWS   = 6;
	localparam int TIMEOUT = NROWS * 120 * BIT_CYC + 2000; // Frames plus AXI traffic

	logic        clk;
	logic        reset;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	axi_resp_e   bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	axi_resp_e   rresp;
	logic        rvalid;
	logic        rready;
	logic        rx_line;
	logic        tx_low;
	logic        con_low;        // Console pulls the line
	logic        wire_level;
	integer      seed;
	int          cycle_cnt = 0;

	logic [23:0] tab_cmd    [NROWS]; // Command bytes, left aligned
	int          tab_bits   [NROWS]; // Bits sent before the stop bit
	logic [79:0] tab_resp   [NROWS]; // Expected answer, left aligned
	int          tab_len    [NROWS]; // Answer bytes, 0 for silence
	logic        tab_rumble [NROWS];
	gc_cmd_e     tab_last   [NROWS];

	assign wire_level = !(tx_low || con_low); // Open drain with pull-up
	assign rx_line    = wire_level;           // DUT hears itself too

	gc_emulator_top u_gc_emulator_top (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT)
			abort_run("Timeout, the run went on longer than all tests need");
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_resp(input string name, input axi_resp_e got,
			input axi_resp_e exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_cmd(input string name, input gc_cmd_e got, input gc_cmd_e exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
			output axi_resp_e resp);
		int stall;
		stall = $unsigned($random(seed)) % 6; // Random bready back-pressure
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(posedge clk); // Address and data taken in this cycle
		check_byte("awready", {7'd0, awready}, 8'h01);
		check_byte("wready", {7'd0, wready}, 8'h01);
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		check_byte("bvalid", {7'd0, bvalid}, 8'h01); // Response one cycle later
		resp    = bresp;
		repeat (stall) begin
			@(negedge clk);
			if (!bvalid)
				abort_run("bvalid dropped before bready was given");
			check_resp("bresp", bresp, resp); // Must hold while stalled
		end
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
		if (bvalid)
			abort_run("bvalid stayed high after bready");
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
			output axi_resp_e resp);
		int stall;
		stall = $unsigned($random(seed)) % 6;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		@(posedge clk); // Nothing pending, so taken at once
		check_byte("arready", {7'd0, arready}, 8'h01);
		@(negedge clk);
		arvalid = 1'b0;
		check_byte("rvalid", {7'd0, rvalid}, 8'h01);
		data    = rdata;
		resp    = rresp;
		repeat (stall) begin
			@(negedge clk);
			if (!rvalid)
				abort_run("rvalid dropped before rready was given");
			check_word("rdata", rdata, data);
			check_resp("rresp", rresp, resp);
		end
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
		if (rvalid)
			abort_run("rvalid stayed high after rready");
	endtask

	// One console bit, 1 short low and 0 long low
	task automatic send_bit(input logic b);
		con_low = 1'b1;
		repeat (b ? QC : 3 * QC) @(negedge clk);
		con_low = 1'b0;
		repeat (b ? 3 * QC : QC) @(negedge clk);
	endtask

	task automatic send_frame(input logic [23:0] cmd, input int nbits);
		@(negedge clk);
		for (int i = 0; i < nbits; i++)
			send_bit(cmd[23 - i]); // MSB first
		send_bit(1'b1);            // Console stop bit
	endtask

	// Pulses classified by low time, stop bit last, each bit one full period
	task automatic receive_response(input int nbytes, output logic [79:0] bytes,
			output logic stop_bit);
		int   lowc;
		int   highc;
		int   prev_low;
		logic b;
		bytes    = '0;
		stop_bit = 1'b0;
		prev_low = 0;
		for (int i = 0; i <= nbytes * 8; i++) begin
			highc = 0;
			while (wire_level) begin
				highc++;
				@(negedge clk);
			end
			if (i > 0 && prev_low + highc != BIT_CYC)
				abort_run($sformatf("DUT bit %0d lasted %0d cycles instead of %0d",
					i - 1, prev_low + highc, BIT_CYC));
			lowc = 0;
			while (!wire_level) begin
				lowc++;
				@(negedge clk);
			end
			if (lowc != QC && lowc != 3 * QC)
				abort_run($sformatf("DUT sent a low pulse of %0d cycles", lowc));
			b = (lowc < 2 * QC);
			if (i < nbytes * 8)
				bytes[79 - i] = b;
			else
				stop_bit = b;
			prev_low = lowc;
		end
	endtask

	task automatic watch_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			if (tx_low)
				abort_run("DUT pulled the line low when no answer was due");
		end
	endtask

	task automatic check_status(input logic exp_rumble, input gc_cmd_e exp_cmd);
		logic [31:0] data;
		axi_resp_e   resp;
		axi_read(`GC_REG_STATUS, data, resp);
		check_resp("rresp", resp, RESP_OKAY);
		check_byte("rumble", {7'd0, data[0]}, {7'd0, exp_rumble});
		check_cmd("last_cmd", gc_cmd_e'(data[5:4]), exp_cmd);
	endtask

	// Byte k from STATE_LO below 4, else STATE_HI
	function automatic logic [79:0] state_bytes(input logic [31:0] lo, input logic [31:0] hi);
		logic [79:0] r;
		r = '0;
		for (int k = 0; k < 4; k++) begin
			r[79 - 8 * k -: 8]       = lo[8 * k +: 8];
			r[79 - 8 * (k + 4) -: 8] = hi[8 * k +: 8];
		end
		return r;
	endfunction

	task automatic set_row(input int r, input logic [23:0] cmd, input int nbits,
			input logic [79:0] resp, input int len, input logic rumble, input gc_cmd_e last);
		tab_cmd[r]    = cmd;
		tab_bits[r]   = nbits;
		tab_resp[r]   = resp;
		tab_len[r]    = len;
		tab_rumble[r] = rumble;
		tab_last[r]   = last;
	endtask

	initial begin
		logic [31:0] lo;
		logic [31:0] hi;
		logic [31:0] data;
		axi_resp_e   resp;
		logic [79:0] got;
		logic        stop_bit;
		seed    = 32'h2d1a;
		reset   = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		con_low = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		check_status(1'b0, CMD_NONE);

		lo = $random(seed);
		hi = $random(seed);
		axi_write(`GC_REG_STATE_LO, lo, resp);
		check_resp("bresp", resp, RESP_OKAY);
		axi_write(`GC_REG_STATE_HI, hi, resp);
		check_resp("bresp", resp, RESP_OKAY);
		axi_read(`GC_REG_STATE_LO, data, resp);
		check_resp("rresp", resp, RESP_OKAY);
		check_word("state_lo", data, lo);
		axi_read(`GC_REG_STATE_HI, data, resp);
		check_resp("rresp", resp, RESP_OKAY);
		check_word("state_hi", data, hi);
		axi_read(4'hc, data, resp);                  // Unmapped
		check_resp("rresp", resp, RESP_SLVERR);
		axi_write(`GC_REG_STATUS, 32'h31, resp);     // Read only
		check_resp("bresp", resp, RESP_SLVERR);

		set_row(0, 24'h000000, 8, {24'h090000, 56'd0}, 3, 1'b0, CMD_ID);
		set_row(1, 24'h400301, 24, state_bytes(lo, hi), 8, 1'b1, CMD_STATUS);
		set_row(2, 24'h400300, 24, state_bytes(lo, hi), 8, 1'b0, CMD_STATUS);
		set_row(3, 24'h410000, 8, 80'h00_80_80_80_80_80_00_00_02_02, 10, 1'b0, CMD_ORIGINS);
		set_row(4, 24'h550000, 8, 80'd0, 0, 1'b0, CMD_ORIGINS);  // Unknown command
		set_row(5, 24'h400300, 16, 80'd0, 0, 1'b0, CMD_ORIGINS); // Cut status frame

		for (int r = 0; r < NROWS; r++) begin
			send_frame(tab_cmd[r], tab_bits[r]);
			if (tab_len[r] != 0) begin
				receive_response(tab_len[r], got, stop_bit);
				for (int k = 0; k < tab_len[r]; k++)
					check_byte($sformatf("row %0d byte %0d", r, k),
						got[79 - 8 * k -: 8], tab_resp[r][79 - 8 * k -: 8]);
				check_byte("stop bit", {7'd0, stop_bit}, 8'h01);
				while (u_gc_emulator_top.u_controller.state != ST_RX) @(negedge clk);
			end
			watch_quiet(4 * BIT_CYC); // Also lets the detector see idle
			check_status(tab_rumble[r], tab_last[r]);
		end

		axi_read(`GC_REG_STATE_HI, data, resp);
		check_resp("rresp", resp, RESP_OKAY);
		check_word("state_hi", data, hi);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/gc_pkg.sv
verilog/gc_quarter_timer.sv
verilog/joybus_bit_detector.sv
verilog/joybus_bit_generator.sv
verilog/gc_controller.sv
verilog/gc_state_regs.sv
verilog/gc_emulator_top.sv
dv/gc_emulator_assertions.sv
dv/gc_emulator_tb.sv

//--- Makefile
TOP = gc_emulator_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
